// File: hdl/lane_seq_pkg.sv
// Lane sequencer shared definitions
package lane_seq_pkg;

  // Number of vector instruction IDs that can be in flight
  localparam int unsigned NrVInsn = 8;

  // Instruction ID and one-bit-per-ID mask
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [NrVInsn-1:0]         vmask_t;

  // Vector register number, 32 architectural registers
  typedef logic [4:0] vreg_t;

  // Vector length or start index, in elements
  typedef logic [15:0] vlen_t;

  // Operand queues of this lane
  localparam int unsigned NrOpQueues = 5;

  // Queue indices into every per-queue array
  localparam int unsigned OpqAluA = 0;
  localparam int unsigned OpqAluB = 1;
  localparam int unsigned OpqFpuA = 2;
  localparam int unsigned OpqFpuB = 3;
  localparam int unsigned OpqFpuC = 4;

  // One bit per operand queue
  typedef logic [NrOpQueues-1:0] opq_mask_t;

  // Lane functional unit that executes an instruction
  typedef enum logic {
    VfuAlu = 1'b0,
    VfuFpu = 1'b1
  } vfu_e;

endpackage

// File: hdl/opq_if.sv
// Operand command bus
interface opq_if;
  import lane_seq_pkg::*;

  // One command slot per operand queue, written on push
  opq_mask_t                 push;
  vid_t   [NrOpQueues-1:0]   cmd_id;
  vreg_t  [NrOpQueues-1:0]   cmd_vs;
  vlen_t  [NrOpQueues-1:0]   cmd_vl;
  vlen_t  [NrOpQueues-1:0]   cmd_vstart;
  vmask_t [NrOpQueues-1:0]   cmd_hazard;

  // Queues that still hold a command
  opq_mask_t                 busy;

  modport issuer (
    output push, cmd_id, cmd_vs, cmd_vl, cmd_vstart, cmd_hazard,
    input  busy
  );

  modport queue (
    input  push, cmd_id, cmd_vs, cmd_vl, cmd_vstart, cmd_hazard,
    output busy
  );

endinterface

// File: hdl/vl_splitter.sv
// Per-lane vector length split
module vl_splitter #(
  parameter int unsigned NrLanes = 4
) (
  input  logic [$clog2(NrLanes)-1:0] lane_id_i,
  input  lane_seq_pkg::vlen_t        vl_i,
  input  lane_seq_pkg::vlen_t        vstart_i,
  output lane_seq_pkg::vlen_t        lane_vl_o,
  output lane_seq_pkg::vlen_t        lane_vstart_o
);
  import lane_seq_pkg::*;

  localparam int unsigned LaneIdW = $clog2(NrLanes);

  logic vl_extra;
  logic vstart_extra;

  // Elements are spread round-robin, so lanes below the remainder get one more
  assign vl_extra     = lane_id_i < vl_i[LaneIdW-1:0];
  assign vstart_extra = lane_id_i < vstart_i[LaneIdW-1:0];

  // NrLanes is a power of two, the quotient is a plain shift
  assign lane_vl_o     = (vl_i >> LaneIdW) + vlen_t'(vl_extra);
  assign lane_vstart_o = (vstart_i >> LaneIdW) + vlen_t'(vstart_extra);

endmodule

// File: hdl/operand_cmd_queue.sv
// Operand command holding registers
module operand_cmd_queue (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  opq_if.queue                                                  opq,
  input  lane_seq_pkg::vmask_t                                  running_i,
  input  lane_seq_pkg::opq_mask_t                               opq_ready_i,
  output lane_seq_pkg::opq_mask_t                               opq_valid_o,
  output lane_seq_pkg::vid_t   [lane_seq_pkg::NrOpQueues-1:0]   opq_id_o,
  output lane_seq_pkg::vreg_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vs_o,
  output lane_seq_pkg::vlen_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vl_o,
  output lane_seq_pkg::vlen_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vstart_o,
  output lane_seq_pkg::vmask_t [lane_seq_pkg::NrOpQueues-1:0]   opq_hazard_o
);
  import lane_seq_pkg::*;

  // A pop and a push at the same edge leave the new command in place
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opq_valid_o <= '0;
    end else begin
      opq_valid_o <= opq.push | (opq_valid_o & ~opq_ready_i);
    end
  end

  // Command payload, loaded on push
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOpQueues; q++) begin
      if (opq.push[q]) begin
        opq_id_o[q]     <= opq.cmd_id[q];
        opq_vs_o[q]     <= opq.cmd_vs[q];
        opq_vl_o[q]     <= opq.cmd_vl[q];
        opq_vstart_o[q] <= opq.cmd_vstart[q];
      end
    end
  end

  // Hazards drop out as soon as the instruction they wait on stops running,
  // also for a command that is pushed at this edge
  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOpQueues; q++) begin
      if (opq.push[q]) begin
        opq_hazard_o[q] <= opq.cmd_hazard[q] & running_i;
      end else begin
        opq_hazard_o[q] <= opq_hazard_o[q] & running_i;
      end
    end
  end

  assign opq.busy = opq_valid_o;

endmodule

// File: hdl/vinsn_tracker.sv
// Running instruction bookkeeping
module vinsn_tracker (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_seq_pkg::vmask_t running_i,
  input  logic                 accept_i,
  input  lane_seq_pkg::vid_t   accept_id_i,
  input  lane_seq_pkg::vmask_t alu_done_i,
  input  lane_seq_pkg::vmask_t fpu_done_i,
  output lane_seq_pkg::vmask_t vinsn_running_o,
  output lane_seq_pkg::vmask_t vinsn_done_o
);
  import lane_seq_pkg::*;

  vmask_t accept_mask;

  assign accept_mask = accept_i ? (vmask_t'(1) << accept_id_i) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vinsn_running_o <= '0;
      vinsn_done_o    <= '0;
    end else begin
      // The main sequencer retires IDs, this lane only adds the accepted one
      vinsn_running_o <= (vinsn_running_o & running_i) | accept_mask;
      // Completion reports from both units, held for a single cycle
      vinsn_done_o    <= alu_done_i | fpu_done_i;
    end
  end

endmodule

// File: hdl/issue_ctrl.sv
// Lane instruction issue control
module issue_ctrl #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [$clog2(NrLanes)-1:0] lane_id_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  lane_seq_pkg::vid_t         req_id_i,
  input  lane_seq_pkg::vfu_e         req_vfu_i,
  input  lane_seq_pkg::vlen_t        req_vl_i,
  input  lane_seq_pkg::vlen_t        req_vstart_i,
  input  lane_seq_pkg::vreg_t        req_vs1_i,
  input  lane_seq_pkg::vreg_t        req_vs2_i,
  input  lane_seq_pkg::vreg_t        req_vd_i,
  input  logic                       req_use_vs1_i,
  input  logic                       req_use_vs2_i,
  input  logic                       req_use_vd_op_i,
  input  logic                       req_swap_i,
  input  lane_seq_pkg::vmask_t       req_hazard_vs1_i,
  input  lane_seq_pkg::vmask_t       req_hazard_vs2_i,
  input  lane_seq_pkg::vmask_t       req_hazard_vd_i,
  input  lane_seq_pkg::vmask_t       running_q_i,
  input  logic                       alu_ready_i,
  input  logic                       fpu_ready_i,
  output logic                       accept_o,
  output lane_seq_pkg::vid_t         accept_id_o,
  output logic                       vfu_valid_o,
  output lane_seq_pkg::vfu_e         vfu_unit_o,
  output lane_seq_pkg::vid_t         vfu_id_o,
  output lane_seq_pkg::vlen_t        vfu_vl_o,
  output lane_seq_pkg::vlen_t        vfu_vstart_o,
  output lane_seq_pkg::vreg_t        vfu_vd_o,
  opq_if.issuer                      opq
);
  import lane_seq_pkg::*;

  vlen_t  lane_vl;
  vlen_t  lane_vstart;
  logic   unit_ready;
  logic   stall;
  logic   alu_busy;
  logic   fpu_busy;
  logic   is_fpu;
  logic   accept;
  vmask_t hazard_vs1;
  vmask_t hazard_vs2;

  vl_splitter #(
    .NrLanes(NrLanes)
  ) vl_splitter_inst (
    .lane_id_i    (lane_id_i),
    .vl_i         (req_vl_i),
    .vstart_i     (req_vstart_i),
    .lane_vl_o    (lane_vl),
    .lane_vstart_o(lane_vstart)
  );

  // A pending operation waits for the unit it targets
  assign unit_ready = (vfu_unit_o == VfuFpu) ? fpu_ready_i : alu_ready_i;
  assign stall      = vfu_valid_o && !unit_ready;

  assign alu_busy = opq.busy[OpqAluA] | opq.busy[OpqAluB];
  assign fpu_busy = opq.busy[OpqFpuA] | opq.busy[OpqFpuB] | opq.busy[OpqFpuC];
  assign is_fpu   = req_vfu_i == VfuFpu;

  // Only the queues of the requested unit can block it
  assign req_ready_o = !stall && !(is_fpu ? fpu_busy : alu_busy) && !running_q_i[req_id_i];
  assign accept      = req_valid_i && req_ready_o;
  assign accept_o    = accept;
  assign accept_id_o = req_id_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_valid_o <= 1'b0;
    end else begin
      vfu_valid_o <= accept || stall;
    end
  end

  // Fields only change on acceptance, which never happens during a stall
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vfu_unit_o   <= req_vfu_i;
      vfu_id_o     <= req_id_i;
      vfu_vl_o     <= lane_vl;
      vfu_vstart_o <= lane_vstart;
      vfu_vd_o     <= req_vd_i;
    end
  end

  // Every source operand also waits on writers of the destination
  assign hazard_vs1 = req_hazard_vs1_i | req_hazard_vd_i;
  assign hazard_vs2 = req_hazard_vs2_i | req_hazard_vd_i;

  always_comb begin
    for (int q = 0; q < NrOpQueues; q++) begin
      opq.cmd_id[q]     = req_id_i;
      opq.cmd_vl[q]     = lane_vl;
      opq.cmd_vstart[q] = lane_vstart;
    end

    opq.cmd_vs[OpqAluA]     = req_vs1_i;
    opq.cmd_hazard[OpqAluA] = hazard_vs1;
    opq.cmd_vs[OpqAluB]     = req_vs2_i;
    opq.cmd_hazard[OpqAluB] = hazard_vs2;
    opq.cmd_vs[OpqFpuA]     = req_vs1_i;
    opq.cmd_hazard[OpqFpuA] = hazard_vs1;

    // Swap exchanges the vs2 and vd operands between FPU queues B and C
    opq.cmd_vs[OpqFpuB]     = req_swap_i ? req_vd_i : req_vs2_i;
    opq.cmd_hazard[OpqFpuB] = req_swap_i ? req_hazard_vd_i : hazard_vs2;
    opq.cmd_vs[OpqFpuC]     = req_swap_i ? req_vs2_i : req_vd_i;
    opq.cmd_hazard[OpqFpuC] = req_swap_i ? hazard_vs2 : req_hazard_vd_i;

    opq.push[OpqAluA] = accept && !is_fpu && req_use_vs1_i;
    opq.push[OpqAluB] = accept && !is_fpu && req_use_vs2_i;
    opq.push[OpqFpuA] = accept && is_fpu && req_use_vs1_i;
    opq.push[OpqFpuB] = accept && is_fpu && (req_swap_i ? req_use_vd_op_i : req_use_vs2_i);
    opq.push[OpqFpuC] = accept && is_fpu && (req_swap_i ? req_use_vs2_i : req_use_vd_op_i);
  end

endmodule

// File: hdl/lane_sequencer.sv
// Lane instruction sequencer
module lane_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [$clog2(NrLanes)-1:0]                            lane_id_i,
  // Main sequencer request
  input  logic                                                  req_valid_i,
  output logic                                                  req_ready_o,
  input  lane_seq_pkg::vid_t                                    req_id_i,
  input  lane_seq_pkg::vfu_e                                    req_vfu_i,
  input  lane_seq_pkg::vlen_t                                   req_vl_i,
  input  lane_seq_pkg::vlen_t                                   req_vstart_i,
  input  lane_seq_pkg::vreg_t                                   req_vs1_i,
  input  lane_seq_pkg::vreg_t                                   req_vs2_i,
  input  lane_seq_pkg::vreg_t                                   req_vd_i,
  input  logic                                                  req_use_vs1_i,
  input  logic                                                  req_use_vs2_i,
  input  logic                                                  req_use_vd_op_i,
  input  logic                                                  req_swap_i,
  input  lane_seq_pkg::vmask_t                                  req_hazard_vs1_i,
  input  lane_seq_pkg::vmask_t                                  req_hazard_vs2_i,
  input  lane_seq_pkg::vmask_t                                  req_hazard_vd_i,
  input  lane_seq_pkg::vmask_t                                  running_i,
  // Unit operation
  output logic                                                  vfu_valid_o,
  output lane_seq_pkg::vfu_e                                    vfu_unit_o,
  output lane_seq_pkg::vid_t                                    vfu_id_o,
  output lane_seq_pkg::vlen_t                                   vfu_vl_o,
  output lane_seq_pkg::vlen_t                                   vfu_vstart_o,
  output lane_seq_pkg::vreg_t                                   vfu_vd_o,
  input  logic                                                  alu_ready_i,
  input  logic                                                  fpu_ready_i,
  input  lane_seq_pkg::vmask_t                                  alu_done_i,
  input  lane_seq_pkg::vmask_t                                  fpu_done_i,
  // Operand queues
  output lane_seq_pkg::opq_mask_t                               opq_valid_o,
  output lane_seq_pkg::vid_t   [lane_seq_pkg::NrOpQueues-1:0]   opq_id_o,
  output lane_seq_pkg::vreg_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vs_o,
  output lane_seq_pkg::vlen_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vl_o,
  output lane_seq_pkg::vlen_t  [lane_seq_pkg::NrOpQueues-1:0]   opq_vstart_o,
  output lane_seq_pkg::vmask_t [lane_seq_pkg::NrOpQueues-1:0]   opq_hazard_o,
  input  lane_seq_pkg::opq_mask_t                               opq_ready_i,
  // Bookkeeping
  output lane_seq_pkg::vmask_t                                  vinsn_running_o,
  output lane_seq_pkg::vmask_t                                  vinsn_done_o
);
  import lane_seq_pkg::*;

  logic accept;
  vid_t accept_id;

  opq_if opq_bus ();

  issue_ctrl #(
    .NrLanes(NrLanes)
  ) issue_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lane_id_i       (lane_id_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_id_i        (req_id_i),
    .req_vfu_i       (req_vfu_i),
    .req_vl_i        (req_vl_i),
    .req_vstart_i    (req_vstart_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_vd_i        (req_vd_i),
    .req_use_vs1_i   (req_use_vs1_i),
    .req_use_vs2_i   (req_use_vs2_i),
    .req_use_vd_op_i (req_use_vd_op_i),
    .req_swap_i      (req_swap_i),
    .req_hazard_vs1_i(req_hazard_vs1_i),
    .req_hazard_vs2_i(req_hazard_vs2_i),
    .req_hazard_vd_i (req_hazard_vd_i),
    .running_q_i     (vinsn_running_o),
    .alu_ready_i     (alu_ready_i),
    .fpu_ready_i     (fpu_ready_i),
    .accept_o        (accept),
    .accept_id_o     (accept_id),
    .vfu_valid_o     (vfu_valid_o),
    .vfu_unit_o      (vfu_unit_o),
    .vfu_id_o        (vfu_id_o),
    .vfu_vl_o        (vfu_vl_o),
    .vfu_vstart_o    (vfu_vstart_o),
    .vfu_vd_o        (vfu_vd_o),
    .opq             (opq_bus.issuer)
  );

  operand_cmd_queue operand_cmd_queue_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .opq         (opq_bus.queue),
    .running_i   (running_i),
    .opq_ready_i (opq_ready_i),
    .opq_valid_o (opq_valid_o),
    .opq_id_o    (opq_id_o),
    .opq_vs_o    (opq_vs_o),
    .opq_vl_o    (opq_vl_o),
    .opq_vstart_o(opq_vstart_o),
    .opq_hazard_o(opq_hazard_o)
  );

  vinsn_tracker vinsn_tracker_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .running_i      (running_i),
    .accept_i       (accept),
    .accept_id_i    (accept_id),
    .alu_done_i     (alu_done_i),
    .fpu_done_i     (fpu_done_i),
    .vinsn_running_o(vinsn_running_o),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

// File: tb/lane_sequencer_asserts.sv
// Lane sequencer handshake assertions
module lane_sequencer_asserts (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    req_ready_o,
  input logic                    vfu_valid_o,
  input lane_seq_pkg::vfu_e      vfu_unit_o,
  input lane_seq_pkg::vid_t      vfu_id_o,
  input lane_seq_pkg::vlen_t     vfu_vl_o,
  input lane_seq_pkg::vlen_t     vfu_vstart_o,
  input lane_seq_pkg::vreg_t     vfu_vd_o,
  input logic                    alu_ready_i,
  input logic                    fpu_ready_i,
  input lane_seq_pkg::opq_mask_t opq_valid_o
);
  import lane_seq_pkg::*;

  logic stalled;
  // Set once any property below has failed
  logic failed = 1'b0;

  // The operation waits while the unit it addresses is busy
  assign stalled = vfu_valid_o && !((vfu_unit_o == VfuFpu) ? fpu_ready_i : alu_ready_i);

  hold_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |=> vfu_valid_o && $stable({vfu_unit_o, vfu_id_o, vfu_vl_o, vfu_vstart_o, vfu_vd_o}))
    else begin
      failed = 1'b1;
      $error("Stalled unit operation changed its fields");
    end

  ready_low_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stalled |-> !req_ready_o)
    else begin
      failed = 1'b1;
      $error("Request ready is high while the unit operation is stalled");
    end

  idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !vfu_valid_o && opq_valid_o == '0)
    else begin
      failed = 1'b1;
      $error("A valid output is high during reset");
    end

endmodule

bind lane_sequencer lane_sequencer_asserts lane_sequencer_asserts_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_ready_o (req_ready_o),
  .vfu_valid_o (vfu_valid_o),
  .vfu_unit_o  (vfu_unit_o),
  .vfu_id_o    (vfu_id_o),
  .vfu_vl_o    (vfu_vl_o),
  .vfu_vstart_o(vfu_vstart_o),
  .vfu_vd_o    (vfu_vd_o),
  .alu_ready_i (alu_ready_i),
  .fpu_ready_i (fpu_ready_i),
  .opq_valid_o (opq_valid_o)
);

// File: tb/tb_lane_sequencer.sv
// Lane sequencer testbench
module tb_lane_sequencer;
  import lane_seq_pkg::*;

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned MaxCycles = 3000;

  // Unit operation and queue commands that one accepted request should produce
  typedef struct packed {
    vid_t                    id;
    vfu_e                    unit;
    vreg_t                   vd;
    vlen_t                   vl;
    vlen_t                   vstart;
    opq_mask_t               push;
    vreg_t  [NrOpQueues-1:0] vs;
    vmask_t [NrOpQueues-1:0] hazard;
  } issue_t;

  logic                    clk_i, rst_ni;
  logic [1:0]              lane_id_i;
  logic                    req_valid_i, req_ready_o;
  vid_t                    req_id_i;
  vfu_e                    req_vfu_i;
  vlen_t                   req_vl_i, req_vstart_i;
  vreg_t                   req_vs1_i, req_vs2_i, req_vd_i;
  logic                    req_use_vs1_i, req_use_vs2_i, req_use_vd_op_i, req_swap_i;
  vmask_t                  req_hazard_vs1_i, req_hazard_vs2_i, req_hazard_vd_i, running_i;
  logic                    vfu_valid_o, alu_ready_i, fpu_ready_i;
  vfu_e                    vfu_unit_o;
  vid_t                    vfu_id_o;
  vlen_t                   vfu_vl_o, vfu_vstart_o;
  vreg_t                   vfu_vd_o;
  vmask_t                  alu_done_i, fpu_done_i, vinsn_running_o, vinsn_done_o;
  opq_mask_t               opq_valid_o, opq_ready_i;
  vid_t   [NrOpQueues-1:0] opq_id_o;
  vreg_t  [NrOpQueues-1:0] opq_vs_o;
  vlen_t  [NrOpQueues-1:0] opq_vl_o, opq_vstart_o;
  vmask_t [NrOpQueues-1:0] opq_hazard_o;

  logic [15:0] lfsr_state = 16'd46744;
  int unsigned cycle_count = 0;
  string       test_name = "reset";
  logic        check_due = 1'b0;
  issue_t      expected;
  vmask_t      held_hazard;
  logic        assert_failed;

  lane_sequencer #(.NrLanes(NrLanes)) lane_sequencer_inst (.*);

  assign assert_failed = lane_sequencer_inst.lane_sequencer_asserts_inst.failed;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else
      fail_run($sformatf("Fail %s: expected %0h, actual %0h", name, exp, act));
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      fail_run("Timeout: the DUT stopped accepting requests before the tests finished");
    end
  end

  // The bound checker flags a failed handshake property
  always @(negedge clk_i) begin
    if (assert_failed === 1'b1) begin
      fail_run("Error: a handshake assertion on the DUT failed");
    end
  end

  // Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
      r[i] = lfsr_state[0];
    end
    return r;
  endfunction

  // Expected result for the request on the inputs, hazards as stored at the edge
  function automatic issue_t reference_issue(input vmask_t run);
    issue_t e;
    vmask_t hz_vs1;
    vmask_t hz_vs2;
    vmask_t hz_vd;
    e = '0;
    e.id   = req_id_i;
    e.unit = req_vfu_i;
    e.vd   = req_vd_i;
    // Element i lives in lane i mod NrLanes
    e.vl     = req_vl_i / NrLanes + ((req_vl_i % NrLanes > lane_id_i) ? 1 : 0);
    e.vstart = req_vstart_i / NrLanes + ((req_vstart_i % NrLanes > lane_id_i) ? 1 : 0);
    hz_vs1 = (req_hazard_vs1_i | req_hazard_vd_i) & run;
    hz_vs2 = (req_hazard_vs2_i | req_hazard_vd_i) & run;
    hz_vd  = req_hazard_vd_i & run;
    if (req_vfu_i == VfuAlu) begin
      e.push[OpqAluA]   = req_use_vs1_i;
      e.vs[OpqAluA]     = req_vs1_i;
      e.hazard[OpqAluA] = hz_vs1;
      e.push[OpqAluB]   = req_use_vs2_i;
      e.vs[OpqAluB]     = req_vs2_i;
      e.hazard[OpqAluB] = hz_vs2;
    end else begin
      e.push[OpqFpuA]   = req_use_vs1_i;
      e.vs[OpqFpuA]     = req_vs1_i;
      e.hazard[OpqFpuA] = hz_vs1;
      e.push[OpqFpuB]   = req_swap_i ? req_use_vd_op_i : req_use_vs2_i;
      e.vs[OpqFpuB]     = req_swap_i ? req_vd_i : req_vs2_i;
      e.hazard[OpqFpuB] = req_swap_i ? hz_vd : hz_vs2;
      e.push[OpqFpuC]   = req_swap_i ? req_use_vs2_i : req_use_vd_op_i;
      e.vs[OpqFpuC]     = req_swap_i ? req_vs2_i : req_vd_i;
      e.hazard[OpqFpuC] = req_swap_i ? hz_vs2 : hz_vd;
    end
    return e;
  endfunction

  // Inputs are stable at the falling edge, so an acceptance seen here happens at the next edge
  always @(negedge clk_i) begin
    if (check_due) begin
      check_value({test_name, " vfu_valid"}, 1, vfu_valid_o);
      check_value({test_name, " vfu_unit"}, expected.unit, vfu_unit_o);
      check_value({test_name, " vfu_id"}, expected.id, vfu_id_o);
      check_value({test_name, " vfu_vl"}, expected.vl, vfu_vl_o);
      check_value({test_name, " vfu_vstart"}, expected.vstart, vfu_vstart_o);
      check_value({test_name, " vfu_vd"}, expected.vd, vfu_vd_o);
      for (int q = 0; q < NrOpQueues; q++) begin
        if ((expected.unit == VfuFpu) == (q >= OpqFpuA)) begin
          check_value($sformatf("%s opq%0d valid", test_name, q), expected.push[q],
                      opq_valid_o[q]);
        end
        if (expected.push[q]) begin
          check_value($sformatf("%s opq%0d id", test_name, q), expected.id, opq_id_o[q]);
          check_value($sformatf("%s opq%0d vs", test_name, q), expected.vs[q], opq_vs_o[q]);
          check_value($sformatf("%s opq%0d vl", test_name, q), expected.vl, opq_vl_o[q]);
          check_value($sformatf("%s opq%0d vstart", test_name, q), expected.vstart,
                      opq_vstart_o[q]);
          check_value($sformatf("%s opq%0d hazard", test_name, q), expected.hazard[q],
                      opq_hazard_o[q]);
        end
      end
    end
    check_due = 1'b0;
    if (rst_ni && req_valid_i && req_ready_o) begin
      expected  = reference_issue(running_i);
      check_due = 1'b1;
    end
  end

  // Flags are {swap, use_vd_op, use_vs2, use_vs1}
  task automatic present_request(input vid_t id, input vfu_e vfu, input logic [3:0] flags,
                                 input vmask_t hazard_vs1);
    @(posedge clk_i);
    req_valid_i      <= 1'b1;
    req_id_i         <= id;
    req_vfu_i        <= vfu;
    {req_swap_i, req_use_vd_op_i, req_use_vs2_i, req_use_vs1_i} <= flags;
    req_hazard_vs1_i <= hazard_vs1;
    req_hazard_vs2_i <= vmask_t'(rand_bits(8));
    req_hazard_vd_i  <= vmask_t'(rand_bits(8));
    req_vl_i         <= vlen_t'(rand_bits(16));
    req_vstart_i     <= vlen_t'(rand_bits(16));
    req_vs1_i        <= vreg_t'(rand_bits(5));
    req_vs2_i        <= vreg_t'(rand_bits(5));
    req_vd_i         <= vreg_t'(rand_bits(5));
    lane_id_i        <= 2'(rand_bits(2));
  endtask

  task automatic wait_accept();
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic expect_refused(input string name);
    repeat (3) begin
      @(negedge clk_i);
      check_value(name, 0, req_ready_o);
    end
  endtask

  initial begin
    vid_t id;
    rst_ni = 1'b0;
    {lane_id_i, req_valid_i, req_id_i, req_vl_i, req_vstart_i} = '0;
    {req_vs1_i, req_vs2_i, req_vd_i, req_use_vs1_i, req_use_vs2_i} = '0;
    {req_use_vd_op_i, req_swap_i, req_hazard_vs1_i, req_hazard_vs2_i} = '0;
    {req_hazard_vd_i, running_i, alu_done_i, fpu_done_i} = '0;
    req_vfu_i   = VfuAlu;
    alu_ready_i = 1'b1;
    fpu_ready_i = 1'b1;
    opq_ready_i = '1;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Random requests cover the length split and the routing of both units
    test_name = "random";
    for (int n = 0; n < 240; n++) begin
      id = vid_t'(rand_bits(3));
      present_request(id, vfu_e'(1'(rand_bits(1))), 4'(rand_bits(4)), vmask_t'(rand_bits(8)));
      running_i <= vmask_t'(rand_bits(8)) & ~(vmask_t'(1) << id);
      wait_accept();
    end
    running_i <= '0;
    repeat (2) @(posedge clk_i);
    running_i <= 8'h3F;
    test_name = "fpu_swap";
    present_request(3'd6, VfuFpu, 4'b1111, vmask_t'(rand_bits(8)));
    wait_accept();
    present_request(3'd7, VfuFpu, 4'b0111, vmask_t'(rand_bits(8)));
    wait_accept();

    test_name = "unit_stall";
    running_i   <= '1;
    alu_ready_i <= 1'b0;
    present_request(3'd1, VfuAlu, 4'b0011, vmask_t'(rand_bits(8)));
    wait_accept();
    present_request(3'd2, VfuFpu, 4'b0111, vmask_t'(rand_bits(8)));
    expect_refused("unit_stall ready");
    @(posedge clk_i);
    alu_ready_i <= 1'b1;
    wait_accept();

    test_name = "queue_hold";
    repeat (2) @(posedge clk_i);
    opq_ready_i <= '0;
    present_request(3'd3, VfuAlu, 4'b0001, 8'h42);
    wait_accept();
    held_hazard = expected.hazard[OpqAluA];
    present_request(3'd4, VfuAlu, 4'b0010, vmask_t'(rand_bits(8)));
    expect_refused("queue_hold ready");
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    present_request(3'd5, VfuFpu, 4'b0001, vmask_t'(rand_bits(8)));
    wait_accept();

    test_name = "hazard_clear";
    @(negedge clk_i);
    check_value("hazard_clear held", held_hazard, opq_hazard_o[OpqAluA]);
    @(posedge clk_i);
    running_i <= 8'hFD;
    repeat (2) @(negedge clk_i);
    check_value("hazard_clear hazard", held_hazard & 8'hFD, opq_hazard_o[OpqAluA]);
    check_value("hazard_clear running", 0, vinsn_running_o[1]);

    test_name = "running_id";
    @(posedge clk_i);
    opq_ready_i <= '1;
    present_request(3'd5, VfuFpu, 4'b0001, vmask_t'(rand_bits(8)));
    expect_refused("running_id ready");
    @(posedge clk_i);
    running_i <= 8'hDD;
    wait_accept();

    test_name = "done_pulse";
    alu_done_i <= 8'h12;
    fpu_done_i <= 8'h40;
    @(posedge clk_i);
    alu_done_i <= '0;
    fpu_done_i <= '0;
    @(negedge clk_i);
    check_value("done_pulse set", 8'h52, vinsn_done_o);
    @(negedge clk_i);
    check_value("done_pulse clear", 8'h00, vinsn_done_o);

    repeat (3) @(negedge clk_i);
    if (assert_failed === 1'b1) begin
      fail_run("Error: a handshake assertion on the DUT failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// File: lane_sequencer.f
hdl/lane_seq_pkg.sv
hdl/opq_if.sv
hdl/vl_splitter.sv
hdl/operand_cmd_queue.sv
hdl/vinsn_tracker.sv
hdl/issue_ctrl.sv
hdl/lane_sequencer.sv
tb/lane_sequencer_asserts.sv
tb/tb_lane_sequencer.sv

// File: Bender.yml
package:
  name: lane_sequencer

sources:
  - files:
      - hdl/lane_seq_pkg.sv
      - hdl/opq_if.sv
      - hdl/vl_splitter.sv
      - hdl/operand_cmd_queue.sv
      - hdl/vinsn_tracker.sv
      - hdl/issue_ctrl.sv
      - hdl/lane_sequencer.sv
  - target: test
    files:
      - tb/lane_sequencer_asserts.sv
      - tb/tb_lane_sequencer.sv
